/* tileRenderPkg.sv */
// Shared definitions for the tile-map VGA renderer.
// Holds the tile geometry, the map layout in video memory, the glyph
// codes that the renderer understands and the colour palette.
// RTL files refer to these by scoped name, never through an import.

package tileRenderPkg;

	// Beam counters and memory words
	typedef logic [15:0] screenCoord;
	typedef logic [15:0] mapAddr;
	typedef logic [15:0] glyphCode;

	// Column plus four times row inside one tile
	typedef logic [3:0] pixelIndex;

	typedef logic [7:0] colourChan;

	typedef struct packed {
		colourChan red;
		colourChan green;
		colourChan blue;
	} rgbPixel;

	// Travels alongside a pixel while its glyph is being fetched
	typedef struct packed {
		logic      visible;
		pixelIndex pixel;
	} pixelTag;

	// Order matters: offset from a team's first path code maps straight onto this
	typedef enum logic [2:0] {
		shapeHorizontal,
		shapeVertical,
		shapeCorner,
		shapeLeftDown,
		shapeLeftUp,
		shapeRightDown,
		shapeRightUp
	} pathShape;

	localparam int PathShapes = 7;

	// Tile geometry
	localparam int TileSize = 4;
	localparam int TileShift = $clog2(TileSize);

	// Map layout in video memory
	localparam int MapColumns = 160;
	localparam mapAddr MapBase = 16'd40000;

	// Address to data, in clocks
	localparam int MemReadLatency = 1;

	// Address register plus the memory read
	localparam int TagStages = 1 + MemReadLatency;

	// Solid squares
	localparam glyphCode GlyphBlack = 16'd0;
	localparam glyphCode GlyphBlue = 16'd1;
	localparam glyphCode GlyphYellow = 16'd2;

	// First code of each team's seven path shapes
	localparam glyphCode GlyphBluePathFirst = 16'd3;
	localparam glyphCode GlyphYellowPathFirst = 16'd28;

	// Palette
	localparam rgbPixel ColourBlack = '{red: 8'd0, green: 8'd0, blue: 8'd0};
	localparam rgbPixel ColourBlue = '{red: 8'd0, green: 8'd0, blue: 8'd255};
	localparam rgbPixel ColourYellow = '{red: 8'd255, green: 8'd255, blue: 8'd0};

	// Blue team trail
	localparam rgbPixel ColourBlueEdge = '{red: 8'd0, green: 8'd162, blue: 8'd230};
	localparam rgbPixel ColourBlueInner = '{red: 8'd156, green: 8'd219, blue: 8'd230};

	// Yellow team trail
	localparam rgbPixel ColourYellowEdge = '{red: 8'd255, green: 8'd201, blue: 8'd14};
	localparam rgbPixel ColourYellowInner = '{red: 8'd255, green: 8'd254, blue: 8'd145};

endpackage

/* tileAddrGen.sv */
// First pipeline stage of the tile renderer.
// Turns the beam position into the word address of the tile under it and
// registers that address towards the video memory. The pixel's place in
// the tile and its blanking state are delayed so they line up with the
// glyph word when the memory returns it.

module tileAddrGen (
	input  logic                     clk,
	input  logic                     arstN,
	input  logic                     bright,
	input  tileRenderPkg::screenCoord hCount,
	input  tileRenderPkg::screenCoord vCount,
	output tileRenderPkg::mapAddr     memAddress,
	output tileRenderPkg::pixelTag    tag
);

	tileRenderPkg::mapAddr tileColumn;
	tileRenderPkg::mapAddr tileRow;
	tileRenderPkg::mapAddr rowOffset;
	tileRenderPkg::mapAddr nextAddress;
	tileRenderPkg::pixelTag nowTag;

	// Stage 0 feeds from nowTag, last stage lines up with memData
	tileRenderPkg::pixelTag tagPipe [tileRenderPkg::TagStages];

	// Tile under the beam
	assign tileColumn = hCount / tileRenderPkg::screenCoord'(tileRenderPkg::TileSize);
	assign tileRow = vCount / tileRenderPkg::screenCoord'(tileRenderPkg::TileSize);

	// Row stride uses the tile row, not the raw line count
	assign rowOffset = tileRow * tileRenderPkg::mapAddr'(tileRenderPkg::MapColumns);
	assign nextAddress = tileRenderPkg::MapBase + tileColumn + rowOffset;

	// Low counter bits give the position inside the tile
	assign nowTag.visible = bright;
	assign nowTag.pixel = {
		vCount[tileRenderPkg::TileShift-1:0],
		hCount[tileRenderPkg::TileShift-1:0]
	};

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			memAddress <= '0;
			for (int i = 0; i < tileRenderPkg::TagStages; i++) begin
				tagPipe[i] <= '0;
			end
		end else begin
			memAddress <= nextAddress;
			tagPipe[0] <= nowTag;
			for (int i = 1; i < tileRenderPkg::TagStages; i++) begin
				tagPipe[i] <= tagPipe[i-1];
			end
		end
	end

	assign tag = tagPipe[tileRenderPkg::TagStages-1];

endmodule

/* pathMask.sv */
// Edge masks of the trail path shapes.
// Given a shape and a pixel position inside a 4x4 tile, tells whether the
// pixel lies on the outer edge of the trail. Both teams share these masks,
// the shader only picks the colours. Purely combinational.

module pathMask (
	input  tileRenderPkg::pathShape  shape,
	input  tileRenderPkg::pixelIndex pixel,
	output logic                     onEdge
);

	// One bit per tile pixel, bit index = column + 4 * row
	logic [15:0] edgeSet;

	// Masks are written row 3 first, column 3 leftmost in each row,
	// so the pictures below are mirrored left to right
	always_comb begin
		case (shape)
			// Top and bottom rows
			tileRenderPkg::shapeHorizontal: edgeSet = {
				4'b1111,
				4'b0000,
				4'b0000,
				4'b1111
			};
			// Left and right columns
			tileRenderPkg::shapeVertical: edgeSet = {
				4'b1001,
				4'b1001,
				4'b1001,
				4'b1001
			};
			// Whole border, only the centre four are inner
			tileRenderPkg::shapeCorner: edgeSet = {
				4'b1111,
				4'b1001,
				4'b1001,
				4'b1111
			};
			tileRenderPkg::shapeLeftDown: edgeSet = {
				4'b1001,
				4'b1000,
				4'b1000,
				4'b1111
			};
			tileRenderPkg::shapeLeftUp: edgeSet = {
				4'b1111,
				4'b1000,
				4'b1000,
				4'b1001
			};
			tileRenderPkg::shapeRightDown: edgeSet = {
				4'b1001,
				4'b0001,
				4'b0001,
				4'b1111
			};
			tileRenderPkg::shapeRightUp: edgeSet = {
				4'b1111,
				4'b0001,
				4'b0001,
				4'b1001
			};
			// Unused encoding
			default: edgeSet = '0;
		endcase
	end

	assign onEdge = edgeSet[pixel];

endmodule

/* glyphShader.sv */
// Last pipeline stage of the tile renderer.
// Decodes the glyph word returned by video memory together with the tag
// of the pixel it belongs to, and registers the resulting colour.
// Solid squares map straight to the palette; path glyphs are split into
// team and shape, and the shape's edge mask picks edge or inner colour.
// Blanked pixels and unknown codes come out black.

module glyphShader (
	input  logic                    clk,
	input  logic                    arstN,
	input  tileRenderPkg::glyphCode glyph,
	input  tileRenderPkg::pixelTag  tag,
	output tileRenderPkg::rgbPixel  vgaPixel
);

	logic isBluePath;
	logic isYellowPath;
	logic onEdge;
	tileRenderPkg::glyphCode pathOffset;
	tileRenderPkg::pathShape shape;
	tileRenderPkg::rgbPixel nextPixel;

	// Each team owns a run of seven consecutive path codes
	assign isBluePath = (glyph >= tileRenderPkg::GlyphBluePathFirst) &&
		(glyph < tileRenderPkg::GlyphBluePathFirst +
		tileRenderPkg::glyphCode'(tileRenderPkg::PathShapes));
	assign isYellowPath = (glyph >= tileRenderPkg::GlyphYellowPathFirst) &&
		(glyph < tileRenderPkg::GlyphYellowPathFirst +
		tileRenderPkg::glyphCode'(tileRenderPkg::PathShapes));

	// Offset within the team's run selects the shape
	assign pathOffset = isYellowPath ?
		glyph - tileRenderPkg::GlyphYellowPathFirst :
		glyph - tileRenderPkg::GlyphBluePathFirst;
	assign shape = tileRenderPkg::pathShape'(pathOffset[2:0]);

	pathMask u_pathMask (
		.shape  (shape),
		.pixel  (tag.pixel),
		.onEdge (onEdge)
	);

	always_comb begin
		nextPixel = tileRenderPkg::ColourBlack;
		if (tag.visible) begin
			case (glyph)
				tileRenderPkg::GlyphBlack: nextPixel = tileRenderPkg::ColourBlack;
				tileRenderPkg::GlyphBlue: nextPixel = tileRenderPkg::ColourBlue;
				tileRenderPkg::GlyphYellow: nextPixel = tileRenderPkg::ColourYellow;
				default: begin
					if (isBluePath) begin
						nextPixel = onEdge ?
							tileRenderPkg::ColourBlueEdge :
							tileRenderPkg::ColourBlueInner;
					end else if (isYellowPath) begin
						nextPixel = onEdge ?
							tileRenderPkg::ColourYellowEdge :
							tileRenderPkg::ColourYellowInner;
					end
					// Anything else, bikes included, stays black
				end
			endcase
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			vgaPixel <= '0;
		end else begin
			vgaPixel <= nextPixel;
		end
	end

endmodule

/* tileRenderer.sv */
// Top level of the tile-map VGA renderer.
// Takes the beam position and blanking from the VGA timing block, reads
// the tile's glyph from an external synchronous-read video memory and
// drives one RGB pixel per clock. Output follows the sampled beam
// position by three clocks and never stalls.

module tileRenderer (
	input  logic                     clk,
	input  logic                     arstN,
	input  logic                     bright,
	input  tileRenderPkg::screenCoord hCount,
	input  tileRenderPkg::screenCoord vCount,
	output tileRenderPkg::mapAddr     memAddress,
	input  tileRenderPkg::glyphCode   memData,
	output tileRenderPkg::rgbPixel    vgaPixel
);

	// Pixel tag, aligned with memData
	tileRenderPkg::pixelTag tag;

	tileAddrGen u_tileAddrGen (
		.clk        (clk),
		.arstN      (arstN),
		.bright     (bright),
		.hCount     (hCount),
		.vCount     (vCount),
		.memAddress (memAddress),
		.tag        (tag)
	);

	glyphShader u_glyphShader (
		.clk      (clk),
		.arstN    (arstN),
		.glyph    (memData),
		.tag      (tag),
		.vgaPixel (vgaPixel)
	);

endmodule

/* tileMapModel.sv */
// Video memory model for the tile renderer testbench.
// Synchronous read with one clock of latency, like the block RAM the
// renderer is built for. Every word is a six-bit fold of its whole
// address, so all codes 0 to 63 appear along any map row.

module tileMapModel (
	input  logic                    clk,
	input  tileRenderPkg::mapAddr   address,
	output tileRenderPkg::glyphCode data
);

	timeunit 1ns;
	timeprecision 100ps;

	tileRenderPkg::glyphCode words [65536];
	logic [15:0] fillAddr;

	initial begin
		for (int i = 0; i < 65536; i++) begin
			fillAddr = 16'(i);
			// Low six bits run through all codes inside any aligned block of 64
			words[i] = {10'b0, fillAddr[5:0] ^ fillAddr[11:6] ^ {2'b00, fillAddr[15:12]}};
		end
	end

	always @(posedge clk) begin
		data <= words[address];
	end

endmodule

/* tb_tileRenderer.sv */
// Testbench for the tile-map VGA renderer.
// Streams beam positions into the DUT one pixel per clock, serves glyph
// reads from the map memory model and checks the memory address and the
// output colour against a reference model of the rendering rules.
// Results are expected a fixed three clocks after the inputs are driven.

module tb_tileRenderer;

	timeunit 1ns;
	timeprecision 100ps;

	logic clk = 1'b0;
	logic arstN = 1'b0;
	logic bright = 1'b0;
	tileRenderPkg::screenCoord hCount = '0;
	tileRenderPkg::screenCoord vCount = '0;
	tileRenderPkg::mapAddr memAddress;
	tileRenderPkg::glyphCode memData;
	tileRenderPkg::rgbPixel vgaPixel;

	// Pixels in flight, and the cycle on which each is due at vgaPixel
	tileRenderPkg::rgbPixel expPixels[$];
	int expDue[$];

	int cycle = 0;
	logic addrValid = 1'b0;
	logic anySampled = 1'b0;
	logic anyEmerged = 1'b0;
	tileRenderPkg::mapAddr expAddr = '0;
	int checks = 0;
	int errors = 0;
	int testChecks = 0;
	int testErrors = 0;
	logic timedOut = 1'b0;
	logic [31:0] rngState = 32'heda9;

	always #5 clk = ~clk;

	tileRenderer u_tileRenderer (
		.clk        (clk),
		.arstN      (arstN),
		.bright     (bright),
		.hCount     (hCount),
		.vCount     (vCount),
		.memAddress (memAddress),
		.memData    (memData),
		.vgaPixel   (vgaPixel)
	);

	tileMapModel u_tileMapModel (
		.clk     (clk),
		.address (memAddress),
		.data    (memData)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Same fold as the memory model fills in
	function automatic tileRenderPkg::glyphCode mapWord(input tileRenderPkg::mapAddr a);
		return {10'b0, a[5:0] ^ a[11:6] ^ {2'b00, a[15:12]}};
	endfunction

	// Map word of the tile under the beam
	function automatic tileRenderPkg::mapAddr tileAddress(
		input tileRenderPkg::screenCoord h,
		input tileRenderPkg::screenCoord v
	);
		int a;
		a = int'(tileRenderPkg::MapBase) + int'(h) / tileRenderPkg::TileSize +
			(int'(v) / tileRenderPkg::TileSize) * tileRenderPkg::MapColumns;
		return tileRenderPkg::mapAddr'(a);
	endfunction

	// Bit n set when tile pixel n is an edge pixel of the shape
	function automatic logic [15:0] edgeMask(input int shape);
		case (shape)
			0: return 16'hF00F; // 0-3 and 12-15
			1: return 16'h9999; // 0,3,4,7,8,11,12,15
			2: return 16'hF99F; // all but 5,6,9,10
			3: return 16'h988F; // 0-3,7,11,12,15
			4: return 16'hF889; // 0,3,7,11-15
			5: return 16'h911F; // 0-3,4,8,12,15
			6: return 16'hF119; // 0,3,4,8,12-15
			default: return 16'h0000;
		endcase
	endfunction

	function automatic tileRenderPkg::rgbPixel expectedColour(
		input tileRenderPkg::screenCoord h,
		input tileRenderPkg::screenCoord v,
		input logic b
	);
		tileRenderPkg::glyphCode code;
		logic [15:0] mask;
		int idx;
		code = mapWord(tileAddress(h, v));
		idx = int'(h) % tileRenderPkg::TileSize +
			tileRenderPkg::TileSize * (int'(v) % tileRenderPkg::TileSize);
		if (!b) begin
			return tileRenderPkg::ColourBlack;
		end
		if (code == tileRenderPkg::GlyphBlue) begin
			return tileRenderPkg::ColourBlue;
		end
		if (code == tileRenderPkg::GlyphYellow) begin
			return tileRenderPkg::ColourYellow;
		end
		if (code >= tileRenderPkg::GlyphBluePathFirst &&
			code <= tileRenderPkg::GlyphBluePathFirst + 16'd6) begin
			mask = edgeMask(int'(code - tileRenderPkg::GlyphBluePathFirst));
			return mask[idx] ? tileRenderPkg::ColourBlueEdge : tileRenderPkg::ColourBlueInner;
		end
		if (code >= tileRenderPkg::GlyphYellowPathFirst &&
			code <= tileRenderPkg::GlyphYellowPathFirst + 16'd6) begin
			mask = edgeMask(int'(code - tileRenderPkg::GlyphYellowPathFirst));
			return mask[idx] ? tileRenderPkg::ColourYellowEdge : tileRenderPkg::ColourYellowInner;
		end
		// Code 0, bikes and anything unused
		return tileRenderPkg::ColourBlack;
	endfunction

	task automatic countCheck();
		checks++;
		testChecks++;
	endtask

	task automatic reportError(input string msg);
		$display("Error at %0d ns: %s", $time, msg);
		errors++;
		testErrors++;
	endtask

	task automatic checkOutputs();
		tileRenderPkg::rgbPixel want;
		int due;
		if (addrValid) begin
			countCheck();
			assert (memAddress == expAddr) else
				reportError($sformatf("memAddress is %0d, expected %0d", memAddress, expAddr));
		end else if (!anySampled) begin
			countCheck();
			assert (memAddress == '0) else
				reportError($sformatf("memAddress is %0d before any pixel, expected 0", memAddress));
		end
		if (expDue.size() > 0 && expDue[0] == cycle) begin
			want = expPixels.pop_front();
			due = expDue.pop_front();
			anyEmerged = 1'b1;
			countCheck();
			assert (vgaPixel == want) else
				reportError($sformatf("vgaPixel is %h, expected %h (due cycle %0d)",
					vgaPixel, want, due));
		end else if (!anyEmerged) begin
			countCheck();
			assert (vgaPixel == '0) else
				reportError($sformatf("vgaPixel is %h before any pixel, expected 0", vgaPixel));
		end
	endtask

	// Outputs are settled 1 ns after the edge, inputs change there too
	task automatic awaitEdge();
		@(posedge clk);
		#1;
		cycle++;
		checkOutputs();
	endtask

	task automatic driveAndPredict(
		input tileRenderPkg::screenCoord h,
		input tileRenderPkg::screenCoord v,
		input logic b
	);
		hCount = h;
		vCount = v;
		bright = b;
		expAddr = tileAddress(h, v);
		addrValid = 1'b1;
		anySampled = 1'b1;
		expPixels.push_back(expectedColour(h, v, b));
		// Fixed three-clock latency
		expDue.push_back(cycle + 3);
	endtask

	task automatic stepPixel(
		input tileRenderPkg::screenCoord h,
		input tileRenderPkg::screenCoord v,
		input logic b
	);
		awaitEdge();
		driveAndPredict(h, v, b);
	endtask

	// brightMode 0 blanks, 1 shows, 2 picks bright at random per pixel
	task automatic sweepRow(input tileRenderPkg::screenCoord v, input int brightMode);
		logic b;
		for (int h = 0; h < 640; h++) begin
			if (brightMode == 2) begin
				rngState = xorshift32(rngState);
				b = rngState[0];
			end else begin
				b = (brightMode == 1);
			end
			stepPixel(tileRenderPkg::screenCoord'(h), v, b);
		end
	endtask

	task automatic drainPipeline();
		int waited;
		waited = 0;
		while (expDue.size() > 0 && waited < 20) begin
			awaitEdge();
			addrValid = 1'b0;
			waited++;
		end
		if (expDue.size() > 0) begin
			$display("Timeout: %0d pixels never reached vgaPixel within %0d clocks",
				expDue.size(), waited);
			timedOut = 1'b1;
		end
	endtask

	task automatic startTest();
		testChecks = 0;
		testErrors = 0;
	endtask

	task automatic finishTest(input string name);
		$display("Test %s finished: %0d checks, %0d errors", name, testChecks, testErrors);
	endtask

	initial begin
		tileRenderPkg::screenCoord row;

		// Outputs stay zero in reset and until the first pixel emerges
		startTest();
		repeat (4) awaitEdge();
		arstN = 1'b1;
		driveAndPredict(16'd0, 16'd0, 1'b1);
		for (int h = 1; h < 4; h++) begin
			stepPixel(tileRenderPkg::screenCoord'(h), 16'd0, 1'b1);
		end
		finishTest("reset");

		// Full tile rows so every code meets all 16 pixel positions
		startTest();
		for (int v = 0; v < 4; v++) begin
			sweepRow(tileRenderPkg::screenCoord'(v), 1);
		end
		for (int v = 476; v < 480; v++) begin
			sweepRow(tileRenderPkg::screenCoord'(v), 1);
		end
		finishTest("visible sweep");

		startTest();
		sweepRow(16'd9, 0);
		sweepRow(16'd10, 0);
		finishTest("blanked sweep");

		startTest();
		for (int n = 0; n < 6; n++) begin
			rngState = xorshift32(rngState);
			row = tileRenderPkg::screenCoord'(rngState % 480);
			sweepRow(row, 2);
		end
		drainPipeline();
		finishTest("random rows");

		$display("Totals: %0d checks, %0d errors, %0d timeouts", checks, errors, timedOut);
		if (errors == 0 && !timedOut) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

/* verilog.f */
tileRenderPkg.sv
tileAddrGen.sv
pathMask.sv
glyphShader.sv
tileRenderer.sv
tileMapModel.sv
tb_tileRenderer.sv
